// File: hw/his_pkg.sv
package his_pkg;

    // histogram geometry
    localparam int BIN_NUM    = 8;
    localparam int PIXEL_NUM  = 4;
    // hits per pixel before moving on
    localparam int DATA_NUM   = 2;
    localparam int ACQ_NUM    = 8;
    // one bank holds every bin of every pixel
    localparam int BANK_DEPTH = PIXEL_NUM * BIN_NUM;

    // time-bin code from the timing front end
    typedef logic [$clog2(BIN_NUM)-1:0]    bin_t;
    typedef logic [$clog2(PIXEL_NUM)-1:0]  pixel_t;
    // wide enough for DATA_NUM * ACQ_NUM hits in one bin
    typedef logic [7:0]                    count_t;
    // nested sequencer counters
    typedef logic [$clog2(DATA_NUM)-1:0]   data_idx_t;
    typedef logic [$clog2(ACQ_NUM)-1:0]    acq_idx_t;
    // flat bin address inside one bank
    typedef logic [$clog2(BANK_DEPTH)-1:0] addr_t;

    // one readout beat
    typedef struct packed {
        logic   valid;
        pixel_t pixel;
        bin_t   bin;
        count_t count;
    } his_word_t;

    typedef enum logic {
        rd_idle,
        rd_stream
    } rd_state_t;

endpackage

// File: hw/hit_sequencer.sv
module hit_sequencer (
    input  logic            clk,
    input  logic            combin_res,
    input  logic            hit_valid,
    output his_pkg::pixel_t pixel,
    output logic            his_sel,
    output logic            swap,
    output logic            frame_done
);

    // hit index within the current pixel
    his_pkg::data_idx_t in_cnt;
    // acquisition index within the frame
    his_pkg::acq_idx_t  acq_cnt;

    logic last_in;
    logic last_pixel;
    logic last_acq;

    // wrap conditions of the three nested counters
    assign last_in    = (in_cnt == his_pkg::data_idx_t'(his_pkg::DATA_NUM - 1));
    assign last_pixel = (pixel == his_pkg::pixel_t'(his_pkg::PIXEL_NUM - 1));
    assign last_acq   = (acq_cnt == his_pkg::acq_idx_t'(his_pkg::ACQ_NUM - 1));

    // the hit that closes the frame
    assign swap = hit_valid && last_in && last_pixel && last_acq;

    // counters move only on accepted hits
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            in_cnt  <= '0;
            pixel   <= '0;
            acq_cnt <= '0;
        end else if (hit_valid) begin
            if (!last_in) begin
                in_cnt <= in_cnt + 1'b1;
            end else begin
                in_cnt <= '0;
                // pixel done, step to the next one
                if (!last_pixel) begin
                    pixel <= pixel + 1'b1;
                end else begin
                    pixel <= '0;
                    // all pixels seen, acquisition done
                    if (!last_acq) begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end else begin
                        acq_cnt <= '0;
                    end
                end
            end
        end
    end

    // bank toggle and frame pulse
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            his_sel    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            // single-cycle pulse after the last hit
            frame_done <= swap;
            if (swap) begin
                his_sel <= ~his_sel;
            end
        end
    end

endmodule

// File: hw/his_store.sv
module his_store (
    input  logic            clk,
    input  logic            combin_res,
    input  logic            hit_valid,
    input  his_pkg::bin_t   hit_bin,
    input  his_pkg::pixel_t pixel,
    input  logic            his_sel,
    input  logic            swap,
    input  his_pkg::pixel_t rd_addr_pixel,
    input  his_pkg::bin_t   rd_addr_bin,
    output his_pkg::count_t bin_count,
    output his_pkg::count_t rd_count
);

    // two banks of bin counts
    his_pkg::count_t                 mem [2][his_pkg::BANK_DEPTH];
    // per-bin written flags, cleared in one cycle on swap
    logic [his_pkg::BANK_DEPTH-1:0]  vld [2];

    his_pkg::addr_t  wr_addr;
    his_pkg::addr_t  rd_addr;
    his_pkg::count_t wr_count;
    logic            rd_bank;

    // pixel-major layout, bin in the low bits
    assign wr_addr = {pixel, hit_bin};
    assign rd_addr = {rd_addr_pixel, rd_addr_bin};

    // finished bank is the one not being written
    assign rd_bank = ~his_sel;

    // first hit of a bin starts at 1, stale content ignored
    always_comb begin
        if (vld[his_sel][wr_addr]) begin
            wr_count = mem[his_sel][wr_addr] + 1'b1;
        end else begin
            wr_count = his_pkg::count_t'(1);
        end
    end

    // count storage, only the addressed bin changes
    always_ff @(posedge clk) begin
        if (hit_valid) begin
            mem[his_sel][wr_addr] <= wr_count;
        end
    end

    // valid bits and live count
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            vld[0]    <= '0;
            vld[1]    <= '0;
            bin_count <= '0;
        end else begin
            if (hit_valid) begin
                vld[his_sel][wr_addr] <= 1'b1;
                bin_count             <= wr_count;
            end
            // flash clear of the bank that gets written next
            if (swap) begin
                vld[rd_bank] <= '0;
            end
        end
    end

    // read port on the finished bank
    always_comb begin
        if (vld[rd_bank][rd_addr]) begin
            rd_count = mem[rd_bank][rd_addr];
        end else begin
            // never written this frame
            rd_count = '0;
        end
    end

endmodule

// File: hw/his_readout.sv
module his_readout (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               frame_done,
    input  his_pkg::count_t    rd_count,
    output his_pkg::pixel_t    rd_addr_pixel,
    output his_pkg::bin_t      rd_addr_bin,
    output his_pkg::his_word_t rd_word
);

    his_pkg::rd_state_t state;

    logic last_addr;
    logic emit;

    // last bin of the last pixel
    assign last_addr = (rd_addr_pixel == his_pkg::pixel_t'(his_pkg::PIXEL_NUM - 1)) &&
                       (rd_addr_bin == his_pkg::bin_t'(his_pkg::BIN_NUM - 1));

    // first beat goes out on the frame_done edge itself
    assign emit = (state == his_pkg::rd_stream) ||
                  ((state == his_pkg::rd_idle) && frame_done);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state         <= his_pkg::rd_idle;
            rd_addr_pixel <= '0;
            rd_addr_bin   <= '0;
            rd_word       <= '0;
        end else begin
            rd_word.valid <= emit;
            if (emit) begin
                // capture address with its count
                rd_word.pixel <= rd_addr_pixel;
                rd_word.bin   <= rd_addr_bin;
                rd_word.count <= rd_count;
                // bin minor, pixel major
                if (rd_addr_bin == his_pkg::bin_t'(his_pkg::BIN_NUM - 1)) begin
                    rd_addr_bin   <= '0;
                    rd_addr_pixel <= rd_addr_pixel + 1'b1;
                end else begin
                    rd_addr_bin <= rd_addr_bin + 1'b1;
                end
                if (last_addr) begin
                    // address wraps to zero, ready for next frame
                    rd_addr_pixel <= '0;
                    state         <= his_pkg::rd_idle;
                end else begin
                    state <= his_pkg::rd_stream;
                end
            end
        end
    end

endmodule

// File: hw/his_builder_top.sv
module his_builder_top (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               hit_valid,
    input  his_pkg::bin_t      hit_bin,
    output his_pkg::count_t    bin_count,
    output logic               frame_done,
    output logic               his_sel,
    output his_pkg::his_word_t rd_word
);

    // sequencer to store
    his_pkg::pixel_t pixel;
    logic            swap;

    // readout address into store, count back
    his_pkg::pixel_t rd_addr_pixel;
    his_pkg::bin_t   rd_addr_bin;
    his_pkg::count_t rd_count;

    // pixel, acquisition and frame tracking
    hit_sequencer i_hit_sequencer (
        .clk        (clk),
        .combin_res (combin_res),
        .hit_valid  (hit_valid),
        .pixel      (pixel),
        .his_sel    (his_sel),
        .swap       (swap),
        .frame_done (frame_done)
    );

    // dual histogram banks
    his_store i_his_store (
        .clk           (clk),
        .combin_res    (combin_res),
        .hit_valid     (hit_valid),
        .hit_bin       (hit_bin),
        .pixel         (pixel),
        .his_sel       (his_sel),
        .swap          (swap),
        .rd_addr_pixel (rd_addr_pixel),
        .rd_addr_bin   (rd_addr_bin),
        .bin_count     (bin_count),
        .rd_count      (rd_count)
    );

    // streams the finished bank after each frame
    his_readout i_his_readout (
        .clk           (clk),
        .combin_res    (combin_res),
        .frame_done    (frame_done),
        .rd_count      (rd_count),
        .rd_addr_pixel (rd_addr_pixel),
        .rd_addr_bin   (rd_addr_bin),
        .rd_word       (rd_word)
    );

endmodule

// File: tests/tb_his_builder.sv
module tb_his_builder;

    // clock and stimulus shape
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int unsigned SEED = 32'h9745_d78a;
    // percent chance of an idle gap before a hit
    localparam int GAP_PCT      = 30;
    localparam int MAX_GAP      = 3;
    localparam int FRAME_HITS   = his_pkg::DATA_NUM * his_pkg::PIXEL_NUM * his_pkg::ACQ_NUM;
    localparam int FULL_FRAMES  = 3;
    // partial frame long enough that the third readout completes first
    localparam int PARTIAL_HITS = 40;
    localparam int HIT_TOTAL    = FULL_FRAMES * FRAME_HITS + PARTIAL_HITS + FRAME_HITS;
    localparam int DRAIN_CYCLES = his_pkg::BANK_DEPTH + 16;
    // worst case every hit waits the longest gap
    localparam int TIMEOUT_CYCLES = HIT_TOTAL * (MAX_GAP + 1) + 2 * RESET_CYCLES +
                                    DRAIN_CYCLES + 100;

    logic                 clk;
    logic                 combin_res;
    logic                 hit_valid;
    his_pkg::bin_t        hit_bin;
    his_pkg::count_t      bin_count;
    logic                 frame_done;
    logic                 his_sel;
    his_pkg::his_word_t   rd_word;

    // model state, two banks indexed by pixel and bin
    his_pkg::count_t model_bank [2][his_pkg::PIXEL_NUM][his_pkg::BIN_NUM];
    logic            m_sel;
    int              m_data;
    int              m_pixel;
    int              m_acq;

    // live output checker state
    logic            pend_valid;
    his_pkg::bin_t   pend_bin;
    his_pkg::count_t exp_count;
    logic            exp_fd;
    int              frames_seen;

    // readout checker state
    int              rd_left;
    int              rd_idx;
    logic            rd_parity;
    logic            fin_bank;
    int              word_pixel;
    int              word_bin;
    int              streams_done;

    his_builder_top i_his_builder_top (
        .clk        (clk),
        .combin_res (combin_res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .bin_count  (bin_count),
        .frame_done (frame_done),
        .his_sel    (his_sel),
        .rd_word    (rd_word)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            fail_run("check failed");
        end
    endtask

    // empty banks, counters back to the first hit of a frame
    task automatic model_reset();
        for (int b = 0; b < 2; b++) begin
            for (int p = 0; p < his_pkg::PIXEL_NUM; p++) begin
                for (int t = 0; t < his_pkg::BIN_NUM; t++) begin
                    model_bank[b][p][t] = '0;
                end
            end
        end
        m_sel   = 1'b0;
        m_data  = 0;
        m_pixel = 0;
        m_acq   = 0;
    endtask

    // one accepted hit, returns the new count of its bin
    function automatic his_pkg::count_t ref_hit(input his_pkg::bin_t b, output logic swapped);
        his_pkg::count_t result;
        result = model_bank[m_sel][m_pixel][b] + 8'd1;
        model_bank[m_sel][m_pixel][b] = result;
        swapped = 1'b0;
        m_data++;
        if (m_data == his_pkg::DATA_NUM) begin
            m_data = 0;
            m_pixel++;
            if (m_pixel == his_pkg::PIXEL_NUM) begin
                m_pixel = 0;
                m_acq++;
                if (m_acq == his_pkg::ACQ_NUM) begin
                    // frame complete, new write bank starts empty
                    m_acq   = 0;
                    swapped = 1'b1;
                    m_sel   = ~m_sel;
                    for (int p = 0; p < his_pkg::PIXEL_NUM; p++) begin
                        for (int t = 0; t < his_pkg::BIN_NUM; t++) begin
                            model_bank[m_sel][p][t] = '0;
                        end
                    end
                end
            end
        end
        return result;
    endfunction

    // random idle gaps between hits, random bins
    task automatic send_hits(input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            gap = 0;
            if ($urandom_range(0, 99) < GAP_PCT) begin
                gap = int'($urandom_range(1, MAX_GAP));
            end
            repeat (gap) begin
                @(posedge clk);
                hit_valid <= 1'b0;
            end
            @(posedge clk);
            hit_valid <= 1'b1;
            hit_bin   <= his_pkg::bin_t'($urandom_range(0, his_pkg::BIN_NUM - 1));
        end
        @(posedge clk);
        hit_valid <= 1'b0;
    endtask

    task automatic hold_reset();
        @(posedge clk);
        combin_res <= 1'b0;
        hit_valid  <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        combin_res <= 1'b1;
    endtask

    // stimulus sequence
    initial begin
        combin_res = 1'b0;
        hit_valid  = 1'b0;
        hit_bin    = '0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        combin_res <= 1'b1;
        send_hits(FULL_FRAMES * FRAME_HITS + PARTIAL_HITS);
        // reset lands in the middle of the fourth frame
        hold_reset();
        send_hits(FRAME_HITS);
        repeat (DRAIN_CYCLES) @(posedge clk);
        compare_value("frame_done pulses", 32'(frames_seen), 32'(FULL_FRAMES + 1));
        compare_value("readout streams", 32'(streams_done), 32'(FULL_FRAMES + 1));
        $display("Simulation PASSED");
        $finish;
    end

    // live outputs, checked away from the driving edge
    always @(negedge clk) begin
        if (!combin_res) begin
            model_reset();
            pend_valid = 1'b0;
            exp_count  = '0;
            compare_value("his_sel", 32'(his_sel), 32'(0));
            compare_value("frame_done", 32'(frame_done), 32'(0));
            compare_value("rd_word.valid", 32'(rd_word.valid), 32'(0));
            compare_value("bin_count", 32'(bin_count), 32'(0));
        end else begin
            exp_fd = 1'b0;
            // hit sampled at the last rising edge
            if (pend_valid) begin
                exp_count = ref_hit(pend_bin, exp_fd);
            end
            compare_value("bin_count", 32'(bin_count), 32'(exp_count));
            compare_value("frame_done", 32'(frame_done), 32'(exp_fd));
            compare_value("his_sel", 32'(his_sel), 32'(m_sel));
            if (frame_done) begin
                frames_seen++;
            end
            // what the DUT samples at the next rising edge
            pend_valid = hit_valid;
            pend_bin   = hit_bin;
        end
    end

    // readout stream against the finished model bank
    always @(negedge clk) begin
        if (!combin_res) begin
            rd_left   = 0;
            rd_idx    = 0;
            rd_parity = 1'b0;
        end else begin
            if (rd_word.valid) begin
                if (rd_left == 0) begin
                    fail_run("readout word seen outside of a frame stream");
                end else begin
                    // pixel major, bin minor
                    word_pixel = rd_idx / his_pkg::BIN_NUM;
                    word_bin   = rd_idx % his_pkg::BIN_NUM;
                    compare_value("rd_word.pixel", 32'(rd_word.pixel), 32'(word_pixel));
                    compare_value("rd_word.bin", 32'(rd_word.bin), 32'(word_bin));
                    compare_value("rd_word.count", 32'(rd_word.count),
                                  32'(model_bank[fin_bank][word_pixel][word_bin]));
                    rd_idx++;
                    rd_left--;
                    if (rd_left == 0) begin
                        streams_done++;
                    end
                end
            end else if (rd_left != 0) begin
                fail_run("readout stream late, missing or stopped before the last bin");
            end
            // first word follows one cycle later
            if (frame_done) begin
                fin_bank  = rd_parity;
                rd_parity = ~rd_parity;
                rd_left   = his_pkg::BANK_DEPTH;
                rd_idx    = 0;
            end
        end
    end

    initial begin
        frames_seen  = 0;
        streams_done = 0;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        fail_run("timeout, the stimulus did not complete in the expected time");
    end

endmodule

// File: vlog.f
hw/his_pkg.sv
hw/hit_sequencer.sv
hw/his_store.sv
hw/his_readout.sv
hw/his_builder_top.sv
tests/tb_his_builder.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the histogram builder testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

# compile everything from the file list into one executable
verilator --binary --timing -f vlog.f --top-module tb_his_builder \
    -Mdir "$build_dir" -o tb_his_builder

# run, keep a copy of the output for the verdict
"./$build_dir/tb_his_builder" | tee "$log_file"

if grep -q "Simulation PASSED" "$log_file"; then
    echo "run_sim: pass"
else
    echo "run_sim: fail, see $log_file"
    exit 1
fi
